// File: verilog/adc_defs.svh
`ifndef ADC_DEFS_SVH
`define ADC_DEFS_SVH

//////////////////////////////////////////////////
// ADC timing

`define ADS_MODEL_ID 8 // 8 = ADS8168, 7 = ADS8167, 6 = ADS8166

`define ADS_T_CONV_NS  ((`ADS_MODEL_ID == 8) ? 660  : (`ADS_MODEL_ID == 7) ? 1200 : 2500)
`define ADS_T_CYCLE_NS ((`ADS_MODEL_ID == 8) ? 1000 : (`ADS_MODEL_ID == 7) ? 2000 : 4000)

`define SPI_CLK_HZ 20_000_000

// ns to clocks, rounded up
`define ADS_CONV_CYCLES  ((`ADS_T_CONV_NS * (`SPI_CLK_HZ / 1_000_000) + 999) / 1000)
`define ADS_CYCLE_CYCLES ((`ADS_T_CYCLE_NS * (`SPI_CLK_HZ / 1_000_000) + 999) / 1000)
`define ADS_CS_GAP ((`ADS_CONV_CYCLES > (`ADS_CYCLE_CYCLES - `SPI_FRAME_BITS)) ? \
  `ADS_CONV_CYCLES : (`ADS_CYCLE_CYCLES - `SPI_FRAME_BITS))
`define ADS_CS_HIGH_CYCLES ((`ADS_CS_GAP > 3) ? `ADS_CS_GAP : 3) // 14 for the 8168

//////////////////////////////////////////////////
// Command word fields

`define CMD_OP_MSB     31 // Opcode in [31:30]
`define CMD_TRIG_BIT   29 // Count triggers instead of clocks
`define CMD_CONT_BIT   28 // Another command must follow
`define CMD_COUNT_BITS 26

//////////////////////////////////////////////////
// SPI frame

`define ADC_NUM_CH     8
`define SPI_FRAME_BITS 16
`define SPI_OTF_REQ    2'b10 // On-the-fly sample request prefix

`endif

// File: verilog/adc_cmd_pkg.sv
package adc_cmd_pkg;

`include "adc_defs.svh"

  // Raw word as it sits at the command FIFO head
  typedef logic [`CMD_OP_MSB:0] cmd_word_t;

  // Delay in clocks or number of triggers
  typedef logic [`CMD_COUNT_BITS-1:0] count_t;

  // Opcode in the top two bits
  typedef enum logic [1:0] {
    op_no_op   = 2'b00, // Wait only
    op_adc_rd  = 2'b01, // Read all channels, then wait
    op_set_ord = 2'b10, // Channel order in [23:0]
    op_cancel  = 2'b11  // Abort a running wait
  } cmd_op_e;

  // Sequencer states
  typedef enum logic [2:0] {
    st_idle,
    st_delay,
    st_trig_wait,
    st_adc_rd,
    st_error // Sticky, left by reset only
  } seq_state_e;

endpackage

// File: verilog/adc_spi_pkg.sv
package adc_spi_pkg;

`include "adc_defs.svh"

  typedef logic [2:0] chan_t; // ADC input channel

  // One SPI transfer, request out or reply in
  typedef logic [`SPI_FRAME_BITS-1:0] spi_frame_t;

  typedef logic [`SPI_FRAME_BITS-1:0] sample_t; // Conversion result

  // Two samples, earlier one in the low half
  typedef logic [2*`SPI_FRAME_BITS-1:0] data_word_t;

  typedef logic [3:0] frame_idx_t; // 0..8 within a read

endpackage

// File: verilog/adc_cmd_seq.sv
`timescale 1ns/1ns

`include "adc_defs.svh"

module adc_cmd_seq (
  input  logic                    clk,
  input  logic                    resetn,
  input  adc_cmd_pkg::cmd_word_t  cmd_word,
  input  logic                    cmd_buf_empty,
  input  logic                    trigger,
  input  logic                    frame_done,
  input  logic                    overflow_pulse,
  output logic                    cmd_word_rd_en,
  output logic                    waiting_for_trig,
  output logic                    frame_start,
  output adc_spi_pkg::chan_t      frame_chan,
  output logic                    frame_capture,
  output logic                    unexp_trig,
  output logic                    delay_too_short,
  output logic                    cmd_buf_underflow,
  output logic                    halted
);

  adc_cmd_pkg::seq_state_e  state;
  adc_cmd_pkg::cmd_op_e     op;
  adc_cmd_pkg::count_t      cmd_count, delay_cnt, trig_cnt;
  adc_spi_pkg::chan_t       order [`ADC_NUM_CH];
  adc_spi_pkg::frame_idx_t  frame_idx;
  logic trig_bit, cont_bit;         // Latched from the running command
  logic frame_req, frames_done;
  logic cmd_end, cancel_hit, timed_op, live;
  logic trig_err, short_err, under_err, err;

  assign op        = adc_cmd_pkg::cmd_op_e'(cmd_word[`CMD_OP_MSB -: 2]);
  assign cmd_count = cmd_word[`CMD_COUNT_BITS-1:0];
  assign timed_op  = (op == adc_cmd_pkg::op_no_op) || (op == adc_cmd_pkg::op_adc_rd);
  assign live      = (state != adc_cmd_pkg::st_error);

  //////////////////////////////////////////////////
  // Command completion and FIFO reads

  always_comb begin
    case (state)
      adc_cmd_pkg::st_idle:      cmd_end = 1'b1;
      adc_cmd_pkg::st_delay:     cmd_end = (delay_cnt == '0);
      adc_cmd_pkg::st_trig_wait: cmd_end = (trig_cnt == '0);
      // Only one of the two counters was loaded
      adc_cmd_pkg::st_adc_rd:    cmd_end = frames_done && (delay_cnt == '0) && (trig_cnt == '0);
      default:                   cmd_end = 1'b0;
    endcase
  end

  // Cancel can cut a wait, never a read in flight
  assign cancel_hit = !cmd_buf_empty && (op == adc_cmd_pkg::op_cancel)
                      && ((state == adc_cmd_pkg::st_delay) || (state == adc_cmd_pkg::st_trig_wait)
                          || ((state == adc_cmd_pkg::st_adc_rd) && frames_done));

  assign cmd_word_rd_en = live && !err && !cmd_buf_empty && (cmd_end || cancel_hit);

  assign waiting_for_trig = (state == adc_cmd_pkg::st_trig_wait)
                            || ((state == adc_cmd_pkg::st_adc_rd) && trig_bit && (trig_cnt != '0));
  assign halted = !live;

  //////////////////////////////////////////////////
  // Errors

  assign trig_err  = live && trigger && (state != adc_cmd_pkg::st_trig_wait) && (trig_cnt == '0);
  assign short_err = live && (state == adc_cmd_pkg::st_adc_rd) && !frames_done && !trig_bit
                     && (delay_cnt == '0); // Read outran its delay
  assign under_err = live && (state != adc_cmd_pkg::st_idle) && cmd_end && cont_bit && cmd_buf_empty;
  assign err       = trig_err || short_err || under_err || (live && overflow_pulse);

  always_ff @(posedge clk) begin
    if (!resetn) begin
      unexp_trig        <= 1'b0;
      delay_too_short   <= 1'b0;
      cmd_buf_underflow <= 1'b0;
    end else begin
      if (trig_err)  unexp_trig        <= 1'b1;
      if (short_err) delay_too_short   <= 1'b1;
      if (under_err) cmd_buf_underflow <= 1'b1;
    end
  end

  //////////////////////////////////////////////////
  // State machine

  always_ff @(posedge clk) begin
    if (!resetn) begin
      state <= adc_cmd_pkg::st_idle;
    end else if (err) begin
      state <= adc_cmd_pkg::st_error;
    end else if (cmd_word_rd_en) begin
      case (op)
        adc_cmd_pkg::op_no_op: begin
          state <= cmd_word[`CMD_TRIG_BIT] ? adc_cmd_pkg::st_trig_wait : adc_cmd_pkg::st_delay;
        end
        adc_cmd_pkg::op_adc_rd: state <= adc_cmd_pkg::st_adc_rd;
        default:                state <= adc_cmd_pkg::st_idle; // set_ord, cancel
      endcase
    end else if (cmd_end && live) begin
      state <= adc_cmd_pkg::st_idle; // Done and nothing queued
    end
  end

  // Counters and flag bits load on every accepted command
  always_ff @(posedge clk) begin
    if (!resetn) begin
      delay_cnt <= '0;
      trig_cnt  <= '0;
      trig_bit  <= 1'b0;
      cont_bit  <= 1'b0;
    end else if (cmd_word_rd_en) begin
      delay_cnt <= (timed_op && !cmd_word[`CMD_TRIG_BIT]) ? cmd_count : '0;
      trig_cnt  <= (timed_op && cmd_word[`CMD_TRIG_BIT]) ? cmd_count : '0;
      trig_bit  <= timed_op && cmd_word[`CMD_TRIG_BIT];
      cont_bit  <= timed_op && cmd_word[`CMD_CONT_BIT];
    end else begin
      if (delay_cnt != '0) delay_cnt <= delay_cnt - 1'b1; // One per clock
      if (trigger && (trig_cnt != '0)) trig_cnt <= trig_cnt - 1'b1;
    end
  end

  // Channel order, three bits per slot
  always_ff @(posedge clk) begin
    if (!resetn) begin
      for (int i = 0; i < `ADC_NUM_CH; i++) order[i] <= adc_spi_pkg::chan_t'(i);
    end else if (cmd_word_rd_en && (op == adc_cmd_pkg::op_set_ord)) begin
      for (int i = 0; i < `ADC_NUM_CH; i++) order[i] <= cmd_word[3*i +: 3];
    end
  end

  //////////////////////////////////////////////////
  // Frame sequencing, 8 requests plus one dummy

  assign frame_start   = (state == adc_cmd_pkg::st_adc_rd) && frame_req;
  assign frame_chan    = (frame_idx == `ADC_NUM_CH) ? '0 : order[adc_spi_pkg::chan_t'(frame_idx)];
  assign frame_capture = (frame_idx != '0); // Reply lags request by one frame

  always_ff @(posedge clk) begin
    if (!resetn) begin
      frame_idx   <= '0;
      frame_req   <= 1'b0;
      frames_done <= 1'b0;
    end else if (cmd_word_rd_en && (op == adc_cmd_pkg::op_adc_rd)) begin
      frame_idx   <= '0;
      frame_req   <= 1'b1; // First frame starts next cycle
      frames_done <= 1'b0;
    end else begin
      if (frame_start) frame_req <= 1'b0;
      if (frame_done && (state == adc_cmd_pkg::st_adc_rd)) begin
        if (frame_idx == `ADC_NUM_CH) begin
          frames_done <= 1'b1;
        end else begin
          frame_idx <= adc_spi_pkg::frame_idx_t'(frame_idx + 1'b1);
          frame_req <= 1'b1;
        end
      end
    end
  end

endmodule

// File: verilog/adc_spi_frame.sv
`timescale 1ns/1ns

`include "adc_defs.svh"

module adc_spi_frame (
  input  logic                 clk,
  input  logic                 resetn,
  input  logic                 frame_start,
  input  adc_spi_pkg::chan_t   frame_chan,
  input  logic                 frame_capture,
  input  logic                 halted,
  input  logic                 miso,
  output logic                 frame_done,
  output logic                 sample_valid,
  output adc_spi_pkg::sample_t sample,
  output logic                 n_cs,
  output logic                 mosi
);

  // n_cs falls CS_HIGH cycles after frame_start
  localparam int cs_load = `ADS_CS_HIGH_CYCLES - 2;

  logic [7:0] cs_cnt;
  logic       cs_wait;     // Holding n_cs high before the transfer
  logic [3:0] bit_cnt;     // Bits left after the current one
  logic       capture_q;   // This frame carries a reply worth keeping
  logic       last_bit;
  adc_spi_pkg::spi_frame_t mosi_sr, miso_sr;

  assign last_bit = !n_cs && (bit_cnt == '0);
  assign mosi     = !n_cs && mosi_sr[`SPI_FRAME_BITS-1]; // MSB first, low outside a frame

  //////////////////////////////////////////////////
  // Chip select and bit timing

  always_ff @(posedge clk) begin
    if (!resetn || halted) begin
      cs_wait      <= 1'b0;
      cs_cnt       <= '0;
      bit_cnt      <= '0;
      capture_q    <= 1'b0;
      n_cs         <= 1'b1; // Deselected while halted
      frame_done   <= 1'b0;
      sample_valid <= 1'b0;
    end else begin
      frame_done   <= 1'b0;
      sample_valid <= 1'b0;
      if (frame_start) begin
        cs_wait   <= 1'b1;
        cs_cnt    <= 8'(cs_load);
        capture_q <= frame_capture;
      end else if (cs_wait) begin
        if (cs_cnt == '0) begin
          cs_wait <= 1'b0;
          n_cs    <= 1'b0; // Conversion time has passed
          bit_cnt <= 4'(`SPI_FRAME_BITS - 1);
        end else begin
          cs_cnt <= cs_cnt - 1'b1;
        end
      end else if (last_bit) begin
        n_cs         <= 1'b1;
        frame_done   <= 1'b1; // Cycle after bit 16
        sample_valid <= capture_q;
      end else if (!n_cs) begin
        bit_cnt <= bit_cnt - 1'b1;
      end
    end
  end

  //////////////////////////////////////////////////
  // Shift registers

  always_ff @(posedge clk) begin
    if (frame_start) begin
      // Request word 10 ccc 00000000000
      mosi_sr <= {`SPI_OTF_REQ, frame_chan, 11'd0};
    end else if (!n_cs) begin
      mosi_sr <= {mosi_sr[`SPI_FRAME_BITS-2:0], 1'b0};
    end
    if (!n_cs) miso_sr <= {miso_sr[`SPI_FRAME_BITS-2:0], miso}; // Same clocks as mosi
    if (last_bit) sample <= {miso_sr[`SPI_FRAME_BITS-2:0], miso}; // Include final bit
  end

endmodule

// File: verilog/adc_sample_pack.sv
`timescale 1ns/1ns

module adc_sample_pack (
  input  logic                    clk,
  input  logic                    resetn,
  input  logic                    sample_valid,
  input  adc_spi_pkg::sample_t    sample,
  input  logic                    data_buf_full,
  output adc_spi_pkg::data_word_t data_word,
  output logic                    data_word_wr_en,
  output logic                    data_buf_overflow,
  output logic                    overflow_pulse
);

  adc_spi_pkg::sample_t low_half; // First sample of the pair
  logic                 have_low;

  // Pair tracking and FIFO write
  always_ff @(posedge clk) begin
    if (!resetn) begin
      have_low          <= 1'b0;
      data_word_wr_en   <= 1'b0;
      data_buf_overflow <= 1'b0;
      overflow_pulse    <= 1'b0;
    end else begin
      data_word_wr_en <= 1'b0;
      overflow_pulse  <= 1'b0;
      if (sample_valid) begin
        have_low <= !have_low;
        if (have_low) begin
          if (data_buf_full) begin
            data_buf_overflow <= 1'b1; // Word is lost
            overflow_pulse    <= 1'b1; // Halts the sequencer
          end else begin
            data_word_wr_en <= 1'b1;
          end
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (sample_valid && !have_low) low_half <= sample;
    if (sample_valid && have_low) data_word <= {sample, low_half}; // Earlier sample low
  end

endmodule

// File: verilog/shim_adc_ctrl.sv
`timescale 1ns/1ns

module shim_adc_ctrl (
  input  logic                    clk,
  input  logic                    resetn,
  input  adc_cmd_pkg::cmd_word_t  cmd_word,
  input  logic                    cmd_buf_empty,
  output logic                    cmd_word_rd_en,
  output adc_spi_pkg::data_word_t data_word,
  output logic                    data_word_wr_en,
  input  logic                    data_buf_full,
  input  logic                    trigger,
  output logic                    waiting_for_trig,
  output logic                    unexp_trig,
  output logic                    delay_too_short,
  output logic                    cmd_buf_underflow,
  output logic                    data_buf_overflow,
  output logic                    n_cs,
  output logic                    mosi,
  input  logic                    miso
);

  // Sequencer to SPI engine
  logic                 frame_start, frame_capture, frame_done, halted;
  adc_spi_pkg::chan_t   frame_chan;
  // SPI engine to packer
  logic                 sample_valid, overflow_pulse;
  adc_spi_pkg::sample_t sample;

  adc_cmd_seq seq0 (
    .clk, .resetn, .cmd_word, .cmd_buf_empty, .trigger, .frame_done, .overflow_pulse,
    .cmd_word_rd_en, .waiting_for_trig, .frame_start, .frame_chan, .frame_capture,
    .unexp_trig, .delay_too_short, .cmd_buf_underflow, .halted
  );

  adc_spi_frame spi0 (
    .clk, .resetn, .frame_start, .frame_chan, .frame_capture, .halted, .miso,
    .frame_done, .sample_valid, .sample, .n_cs, .mosi
  );

  adc_sample_pack pack0 (
    .clk, .resetn, .sample_valid, .sample, .data_buf_full,
    .data_word, .data_word_wr_en, .data_buf_overflow, .overflow_pulse
  );

endmodule

// File: dv/adc_model.sv
`timescale 1ns/1ns

module adc_model (
  input  logic clk,
  input  logic n_cs,
  input  logic mosi,
  output logic miso,
  output logic bad_req   // Sticky, set by a malformed request word
);

  logic [15:0] req;      // Request bits shifted in so far
  logic [15:0] reply;    // Answer to the previous request
  int          bit_idx;  // Bits seen in the current frame

  initial begin
    miso    = 1'b0;
    bad_req = 1'b0;
    req     = '0;
    reply   = '0;
    bit_idx = 0;
  end

  //////////////////////////////////////////////////
  // On-the-fly protocol

  // Both directions move on the falling edge, half a cycle before the controller samples
  always @(negedge clk) begin
    if (n_cs !== 1'b0) begin
      if (bit_idx == 16) begin
        // Expect 10 ccc 00000000000
        if ((req[15:14] !== 2'b10) || (req[10:0] !== 11'd0)) bad_req <= 1'b1;
        reply = 16'h5a00 + req[13:11]; // Served during the next frame
      end
      bit_idx = 0; // An aborted frame is simply forgotten
      miso <= 1'b0;
    end else begin
      miso <= (bit_idx < 16) ? reply[15 - bit_idx] : 1'b0; // MSB first
      req = {req[14:0], mosi};
      bit_idx++;
    end
  end

endmodule

// File: dv/tb_adc_ctrl.sv
`timescale 1ns/1ns

module tb_adc_ctrl;

  localparam logic [1:0] op_noop = 2'd0, op_read = 2'd1, op_order = 2'd2, op_cancel = 2'd3;
  localparam int w_trig = 0, w_unexp = 1, w_short = 2, w_under = 3, w_over = 4, w_empty = 5;
  localparam int min_cs_high = 14; // Conversion gap of the 8168

  logic                    clk = 1'b0;
  logic                    resetn, trigger, data_buf_full, miso, bad_req;
  adc_cmd_pkg::cmd_word_t  cmd_word;
  logic                    cmd_buf_empty, cmd_word_rd_en;
  adc_spi_pkg::data_word_t data_word;
  logic                    data_word_wr_en, waiting_for_trig, n_cs, mosi;
  logic                    unexp_trig, delay_too_short, cmd_buf_underflow, data_buf_overflow;
  logic [5:0]              watched; // Status bits the waits look at

  logic [31:0] cmd_q [$];  // Command FIFO contents
  logic [31:0] data_q [$]; // Words the DUT wrote
  logic        pop_pend = 1'b0;
  int          cs_high = 0;
  int          errors = 0, test_errs = 0, tests_run = 0, tests_failed = 0;
  string       test_name = "reset";

  assign watched = {cmd_buf_empty, data_buf_overflow, cmd_buf_underflow, delay_too_short,
                    unexp_trig, waiting_for_trig};

  always #20 clk = ~clk; // 40 ns period

  shim_adc_ctrl dut0 (.*);
  adc_model adc0 (.clk, .n_cs, .mosi, .miso, .bad_req);

  //////////////////////////////////////////////////
  // FIFO models and chip-select monitor

  always @(posedge clk) pop_pend <= cmd_word_rd_en && !cmd_buf_empty; // Head taken this edge

  always @(negedge clk) begin
    if (pop_pend && (cmd_q.size() != 0)) void'(cmd_q.pop_front());
    cmd_buf_empty <= (cmd_q.size() == 0);
    cmd_word      <= (cmd_q.size() == 0) ? '0 : cmd_q[0]; // Head shown ahead of rd_en
  end

  always @(posedge clk) if (data_word_wr_en) data_q.push_back(data_word);

  always @(negedge clk) begin
    if (n_cs !== 1'b0) begin
      cs_high++;
    end else if (cs_high != 0) begin // First bit of a frame
      assert (cs_high >= min_cs_high) else begin
        $display("%s: n_cs was high for only %0d cycles before a frame", test_name, cs_high);
        errors++;
      end
      cs_high = 0;
    end
  end

  //////////////////////////////////////////////////
  // Helpers

  function automatic adc_cmd_pkg::cmd_word_t make_cmd(input logic [1:0] op, input logic trig,
                                                      input logic cont, input logic [25:0] count);
    return {op, trig, cont, 2'b00, count};
  endfunction

  task automatic check_value(input string what, input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp) else begin
      $display("error %s %s expected %h actual %h", test_name, what, exp, act);
      errors++;
    end
  endtask

  task automatic reset_dut();
    resetn        = 1'b0;
    trigger       = 1'b0;
    data_buf_full = 1'b0;
    cmd_q.delete();
    data_q.delete();
    repeat (3) @(negedge clk);
    resetn = 1'b1;
  endtask

  task automatic push_cmd(input adc_cmd_pkg::cmd_word_t w);
    @(posedge clk);
    cmd_q.push_back(w);
    @(negedge clk);
  endtask

  task automatic pulse_trigger();
    trigger = 1'b1;
    @(negedge clk);
    trigger = 1'b0;
    @(negedge clk);
  endtask

  // Steps first, so a value driven on this edge is never mistaken for the old one
  task automatic wait_bit(input int idx, input logic level, input int limit, input string what);
    for (int i = 0; i < limit; i++) begin
      @(negedge clk);
      if (watched[idx] === level) break;
    end
    assert (watched[idx] === level) else begin
      $display("%s: %s did not happen within %0d cycles", test_name, what, limit);
      errors++;
    end
  endtask

  task automatic check_read(input logic [23:0] ord);
    logic [31:0] exp;
    for (int i = 0; i < 1500; i++) begin
      @(negedge clk);
      if (data_q.size() >= 4) break;
    end
    assert (data_q.size() >= 4) else begin
      $display("%s: only %0d of 4 data words arrived", test_name, data_q.size());
      errors++;
    end
    for (int i = 0; (i < 4) && (i < data_q.size()); i++) begin
      exp = {16'h5a00 + ord[6*i+3 +: 3], 16'h5a00 + ord[6*i +: 3]}; // Earlier channel low
      check_value($sformatf("word %0d", i), exp, data_q[i]);
    end
    check_value("flags", 32'd0, 32'(watched[4:1]));
    check_value("request format", 32'd0, 32'(bad_req));
    data_q.delete();
  endtask

  // Error state holds off new commands and keeps the ADC deselected
  task automatic expect_halt(input logic [3:0] flags);
    check_value("flags", 32'(flags), 32'(watched[4:1]));
    push_cmd(make_cmd(op_read, 1'b0, 1'b0, 26'd400));
    repeat (40) begin
      @(negedge clk);
      assert (!cmd_word_rd_en && n_cs) else begin
        $display("%s: controller left the error state", test_name);
        errors++;
      end
    end
  endtask

  task automatic start_test(input string name);
    test_name = name;
    test_errs = errors;
  endtask

  task automatic end_test();
    tests_run++;
    if (errors == test_errs) begin
      $display("test %s ok", test_name);
    end else begin
      tests_failed++;
      $display("test %s failed with %0d errors", test_name, errors - test_errs);
    end
  endtask

  //////////////////////////////////////////////////
  // Stimulus

  initial begin
    int          seed;
    int          j;
    logic [2:0]  tmp;
    logic [23:0] dflt, ord;
    seed = 6;
    void'($urandom(seed));
    resetn        = 1'b0;
    trigger       = 1'b0;
    data_buf_full = 1'b0;
    cmd_word      = '0;
    cmd_buf_empty = 1'b1;
    for (int i = 0; i < 8; i++) dflt[3*i +: 3] = 3'(i); // Reset order 0..7

    reset_dut();
    start_test("default_read");
    push_cmd(make_cmd(op_read, 1'b0, 1'b0, 26'd400));
    check_read(dflt);
    end_test();

    start_test("set_order");
    ord = dflt;
    for (int i = 7; i > 0; i--) begin // Shuffle
      j   = $urandom % (i + 1);
      tmp = ord[3*i +: 3];
      ord[3*i +: 3] = ord[3*j +: 3];
      ord[3*j +: 3] = tmp;
    end
    push_cmd(make_cmd(op_order, 1'b0, 1'b0, {2'b00, ord}));
    push_cmd(make_cmd(op_read, 1'b0, 1'b0, 26'd400));
    check_read(ord);
    end_test();

    start_test("triggers");
    push_cmd(make_cmd(op_noop, 1'b1, 1'b0, 26'd3));
    wait_bit(w_trig, 1'b1, 1000, "waiting_for_trig");
    pulse_trigger();
    pulse_trigger();
    repeat (3) @(negedge clk);
    check_value("waiting after 2 triggers", 32'd1, 32'(waiting_for_trig));
    pulse_trigger();
    wait_bit(w_trig, 1'b0, 10, "release after 3 triggers");
    check_value("flags", 32'd0, 32'(watched[4:1]));
    pulse_trigger(); // Nothing is waiting now
    wait_bit(w_unexp, 1'b1, 10, "unexp_trig");
    expect_halt(4'b0001);
    end_test();

    reset_dut();
    start_test("cancel");
    push_cmd(make_cmd(op_noop, 1'b0, 1'b0, 26'd100000));
    wait_bit(w_empty, 1'b1, 20, "no-op accept");
    repeat (50) @(negedge clk);
    push_cmd(make_cmd(op_cancel, 1'b0, 1'b0, 26'd0));
    wait_bit(w_empty, 1'b1, 20, "cancel accept");
    push_cmd(make_cmd(op_read, 1'b0, 1'b0, 26'd400)); // Needs idle to start in time
    check_read(dflt);
    end_test();

    reset_dut();
    start_test("delay_short");
    push_cmd(make_cmd(op_read, 1'b0, 1'b0, 26'd10));
    wait_bit(w_short, 1'b1, 100, "delay_too_short");
    expect_halt(4'b0010);
    end_test();

    reset_dut();
    start_test("cmd_underflow");
    push_cmd(make_cmd(op_noop, 1'b0, 1'b1, 26'd20)); // Expects a follower that never comes
    wait_bit(w_under, 1'b1, 100, "cmd_buf_underflow");
    expect_halt(4'b0100);
    end_test();

    reset_dut();
    start_test("data_overflow");
    data_buf_full = 1'b1;
    push_cmd(make_cmd(op_read, 1'b0, 1'b0, 26'd400));
    wait_bit(w_over, 1'b1, 1000, "data_buf_overflow");
    data_buf_full = 1'b0;
    check_value("words written", 32'd0, 32'(data_q.size()));
    expect_halt(4'b1000);
    end_test();

    $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

// File: flist.f
+incdir+verilog
verilog/adc_cmd_pkg.sv
verilog/adc_spi_pkg.sv
verilog/adc_cmd_seq.sv
verilog/adc_spi_frame.sv
verilog/adc_sample_pack.sv
verilog/shim_adc_ctrl.sv
dv/adc_model.sv
dv/tb_adc_ctrl.sv
